//--- project.f
verilog/factPkg.sv
verilog/factDatapath.sv
verilog/factCtrl.sv
verilog/factAxiRegs.sv
verilog/factAccel.sv
sim/factTb.sv

//--- sim/factTb.sv
module factTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MaxVecs      = 64;
    localparam int CyclesPerVec = 40;   // worst vector is a run of n = 12

    logic               CLK;
    logic               RST;
    factPkg::axiLiteReq req;
    factPkg::axiLiteRsp rsp;

    logic [43:0] vecs [0:MaxVecs-1];   // op, addr, aux, data
    int          numVecs;
    bit          vecsLoaded;
    logic [31:0] rngState;

    factAccel DUT (
        .CLK    (CLK),
        .RST    (RST),
        .axiReq (req),
        .axiRsp (rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks and helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic stopOnError(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkData(input logic [factPkg::DataWidth-1:0] got,
                             input logic [factPkg::DataWidth-1:0] exp, input string what);
        if (got !== exp) begin
            stopOnError($sformatf("mismatch at %0d ns: %s got %h expected %h",
                                  $time, what, got, exp));
        end
    endtask

    // bresp and rresp must both be okay
    task automatic checkResp(input logic [1:0] got, input string what);
        if (got !== 2'b00) begin
            stopOnError($sformatf("mismatch at %0d ns: %s got %b expected OKAY",
                                  $time, what, got));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 0 to 3 idle cycles before bready or rready
    task automatic backPressure();
        rngState = xorshift(rngState);
        repeat (rngState[1:0]) @(negedge CLK);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // axi master
    ////////////////////////////////////////////////////////////////////////////

    task automatic axiWrite(input logic [3:0] addr, input logic [3:0] strb,
                            input logic [31:0] data);
        @(negedge CLK);
        req.awaddr  = addr;
        req.awvalid = 1'b1;
        req.wdata   = data;
        req.wstrb   = strb;
        req.wvalid  = 1'b1;
        @(posedge CLK);
        while (!(rsp.awready && rsp.wready)) @(posedge CLK);   // aw and w taken on one edge
        @(negedge CLK);
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        if (!rsp.bvalid) begin
            stopOnError("write response did not follow the write handshake");
        end
        checkResp(rsp.bresp, "bresp");
        backPressure();
        req.bready = 1'b1;
        @(negedge CLK);
        req.bready = 1'b0;
    endtask

    task automatic axiRead(input logic [3:0] addr, output logic [31:0] data);
        @(negedge CLK);
        req.araddr  = addr;
        req.arvalid = 1'b1;
        @(posedge CLK);
        while (!rsp.arready) @(posedge CLK);
        @(negedge CLK);
        req.arvalid = 1'b0;
        if (!rsp.rvalid) begin
            stopOnError("read data did not follow the address handshake");
        end
        checkResp(rsp.rresp, "rresp");
        data = rsp.rdata;   // held while rvalid
        backPressure();
        req.rready = 1'b1;
        @(negedge CLK);
        req.rready = 1'b0;
    endtask

    task automatic pollDone(input logic [3:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        got = '0;
        while (!got[0]) begin
            axiRead(addr, got);
        end
        checkData(got, exp, "status after done");
    endtask

    task automatic runFactorial(input logic [3:0] n, input logic [3:0] status,
                                input logic [31:0] result);
        logic [31:0] got;
        axiWrite(factPkg::RegOperand, 4'hF, {28'd0, n});
        axiWrite(factPkg::RegControl, 4'hF, 32'd1);
        pollDone(factPkg::RegStatus, {28'd0, status});
        axiRead(factPkg::RegResult, got);
        checkData(got, result, $sformatf("result for n=%0d", n));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // vectors and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [31:0] got;
        logic [3:0]  op;
        logic [3:0]  addr;
        logic [3:0]  aux;
        logic [31:0] data;
        rngState = 32'd14022;
        RST      = 1'b1;
        req      = '0;
        $readmemh("sim/factVectors.txt", vecs);
        numVecs = 0;
        while (numVecs < MaxVecs && vecs[numVecs][43:40] inside {[4'h1:4'h4]}) begin
            numVecs++;
        end
        if (numVecs == 0) begin
            stopOnError("no vectors could be read from sim/factVectors.txt");
        end
        vecsLoaded = 1'b1;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        for (int i = 0; i < numVecs; i++) begin
            {op, addr, aux, data} = vecs[i];
            case (op)
                4'h1: axiWrite(addr, aux, data);   // aux is wstrb
                4'h2: begin
                    axiRead(addr, got);
                    checkData(got, data, $sformatf("vector %0d read of %h", i, addr));
                end
                4'h3: pollDone(addr, data);
                4'h4: runFactorial(addr, aux, data);
            endcase
        end
        @(negedge CLK);
        $display("Testbench passed");
        $finish;
    end

    initial begin : watchdog
        wait (vecsLoaded);
        repeat (numVecs * CyclesPerVec) @(posedge CLK);
        stopOnError($sformatf("the run timed out after %0d cycles", numVecs * CyclesPerVec));
    end

endmodule

//--- sim/factVectors.txt
// op_addr_aux_data: op 1 write (aux is wstrb), 2 read and compare data, 3 poll addr until done
// then compare data, 4 run n = addr (aux is expected status, data is expected result)
2_0_0_00000000
2_4_0_00000000
2_8_0_00000000
2_C_0_00000000
1_0_F_000000A5
2_0_0_00000005
1_0_E_00000009
2_0_0_00000005
4_0_1_00000001
4_1_1_00000001
4_2_1_00000002
4_3_1_00000006
4_4_1_00000018
4_5_1_00000078
4_6_1_000002D0
4_7_1_000013B0
4_8_1_00009D80
4_9_1_00058980
4_A_1_00375F00
4_B_1_02611500
4_C_1_1C8CFC00
4_D_3_00000000
4_E_3_00000000
4_F_3_00000000
// second start while busy
1_0_1_0000000C
1_4_1_00000001
2_4_0_00000001
1_4_1_00000001
3_8_0_00000001
2_C_0_1C8CFC00
// misaligned offsets
2_1_0_00000000
2_2_0_00000000
2_3_0_00000000

//--- verilog/factAccel.sv
module factAccel (
    input  logic               CLK,
    input  logic               RST,
    input  factPkg::axiLiteReq axiReq,
    output factPkg::axiLiteRsp axiRsp
);

    logic [factPkg::OperandWidth-1:0] operand;
    logic                             start;
    logic                             busy;
    logic                             finish;
    logic                             failed;
    factPkg::dpCtrl                   dpCtrl;
    factPkg::dpFlags                  dpFlags;
    logic [factPkg::DataWidth-1:0]    product;

    factAxiRegs uRegs (
        .CLK     (CLK),
        .RST     (RST),
        .axiReq  (axiReq),
        .axiRsp  (axiRsp),
        .operand (operand),
        .start   (start),
        .busy    (busy),
        .finish  (finish),
        .failed  (failed),
        .product (product)
    );

    factCtrl uCtrl (
        .CLK    (CLK),
        .RST    (RST),
        .start  (start),
        .flags  (dpFlags),
        .ctrl   (dpCtrl),
        .busy   (busy),
        .finish (finish),
        .failed (failed)
    );

    factDatapath uDatapath (
        .CLK     (CLK),
        .RST     (RST),
        .operand (operand),
        .ctrl    (dpCtrl),
        .flags   (dpFlags),
        .product (product)
    );

endmodule

//--- verilog/factAxiRegs.sv
module factAxiRegs (
    input  logic                                CLK,
    input  logic                                RST,
    input  factPkg::axiLiteReq                  axiReq,
    output factPkg::axiLiteRsp                  axiRsp,
    output logic [factPkg::OperandWidth-1:0]    operand,
    output logic                                start,
    input  logic                                busy,
    input  logic                                finish,
    input  logic                                failed,
    input  logic [factPkg::DataWidth-1:0]       product
);

    factPkg::regAddr                wrAddr;
    factPkg::regAddr                rdAddr;
    logic                           wrAccept;
    logic                           rdAccept;
    logic                           bvalid;
    logic                           rvalid;
    logic [factPkg::DataWidth-1:0]  rdata;
    logic [factPkg::DataWidth-1:0]  rdMux;
    logic [factPkg::DataWidth-1:0]  result;
    logic                           done;
    logic                           error;

    ////////////////////////////////////////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////////////////////////////////////////

    assign wrAddr   = factPkg::regAddr'(axiReq.awaddr);
    assign rdAddr   = factPkg::regAddr'(axiReq.araddr);
    assign wrAccept = axiReq.awvalid && axiReq.wvalid && !bvalid;  // aw and w taken together
    assign rdAccept = axiReq.arvalid && !rvalid;

    // only byte 0 carries writable bits
    assign start = wrAccept && (wrAddr == factPkg::RegControl) && axiReq.wstrb[0]
                   && axiReq.wdata[0] && !busy;

    always_comb begin
        axiRsp         = '0;
        axiRsp.awready = wrAccept;
        axiRsp.wready  = wrAccept;
        axiRsp.bresp   = 2'b00;     // always okay
        axiRsp.bvalid  = bvalid;
        axiRsp.arready = rdAccept;
        axiRsp.rdata   = rdata;
        axiRsp.rresp   = 2'b00;
        axiRsp.rvalid  = rvalid;
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            bvalid <= 1'b0;
        end else if (wrAccept) begin
            bvalid <= 1'b1;
        end else if (axiReq.bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            rvalid <= 1'b0;
        end else if (rdAccept) begin
            rvalid <= 1'b1;
        end else if (axiReq.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (rdAccept) begin
            rdata <= rdMux;   // held until rready
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // register file
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            operand <= '0;
        end else if (wrAccept && (wrAddr == factPkg::RegOperand) && axiReq.wstrb[0]) begin
            operand <= axiReq.wdata[factPkg::OperandWidth-1:0];
        end
    end

    // done and error clear on start, set at end of run
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            done   <= 1'b0;
            error  <= 1'b0;
            result <= '0;
        end else if (start) begin
            done  <= 1'b0;
            error <= 1'b0;
        end else if (finish) begin
            done   <= 1'b1;
            error  <= failed;
            result <= failed ? '0 : product;
        end
    end

    always_comb begin
        rdMux = '0;   // unmapped and misaligned offsets
        case (rdAddr)
            factPkg::RegOperand: rdMux[factPkg::OperandWidth-1:0] = operand;
            factPkg::RegControl: rdMux[0] = busy;
            factPkg::RegStatus:  rdMux[2:0] = {busy, error, done};
            factPkg::RegResult:  rdMux = result;
            default:             rdMux = '0;
        endcase
    end

    // a write offered by the master stays up until it is taken
    assert property (@(posedge CLK) disable iff (RST)
        axiReq.awvalid && !wrAccept |=> axiReq.awvalid);

    // control unit leaves idle on every start
    assert property (@(posedge CLK) disable iff (RST) start |=> busy);

endmodule

//--- verilog/factCtrl.sv
module factCtrl (
    input  logic            CLK,
    input  logic            RST,
    input  logic            start,
    input  factPkg::dpFlags flags,
    output factPkg::dpCtrl  ctrl,
    output logic            busy,
    output logic            finish,
    output logic            failed
);

    factPkg::ctrlState state;
    factPkg::ctrlState nextState;
    logic              errSeen;   // range error caught in load

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state <= factPkg::StIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            factPkg::StIdle: begin
                if (start) begin
                    nextState = factPkg::StLoad;
                end
            end
            factPkg::StLoad: begin
                // bad n skips the multiply loop
                nextState = flags.outOfRange ? factPkg::StFinish : factPkg::StMul;
            end
            factPkg::StMul: begin
                if (!flags.countAboveOne) begin
                    nextState = factPkg::StFinish;
                end
            end
            factPkg::StFinish: nextState = factPkg::StIdle;
            default:           nextState = factPkg::StIdle;
        endcase
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            errSeen <= 1'b0;
        end else if (state == factPkg::StLoad) begin
            errSeen <= flags.outOfRange;
        end
    end

    // datapath strobes
    assign ctrl.loadOperand = (state == factPkg::StLoad);
    assign ctrl.mulStep     = (state == factPkg::StMul) && flags.countAboveOne;

    assign busy   = (state != factPkg::StIdle);
    assign finish = (state == factPkg::StFinish);   // single cycle
    assign failed = finish && errSeen;

    // a good run ends with the count spent
    assert property (@(posedge CLK) disable iff (RST)
        finish && !failed |-> !flags.countAboveOne);

    // a legal n ends the multiply loop within MaxOperand steps
    assert property (@(posedge CLK) disable iff (RST)
        ctrl.loadOperand && !flags.outOfRange
        |=> ##[0:factPkg::MaxOperand] !flags.countAboveOne);

endmodule

//--- verilog/factDatapath.sv
module factDatapath (
    input  logic                                CLK,
    input  logic                                RST,
    input  logic [factPkg::OperandWidth-1:0]    operand,
    input  factPkg::dpCtrl                      ctrl,
    output factPkg::dpFlags                     flags,
    output logic [factPkg::DataWidth-1:0]       product
);

    logic [factPkg::OperandWidth-1:0] count;   // multiplies down from n
    logic [factPkg::DataWidth-1:0]    acc;
    logic [factPkg::DataWidth-1:0]    countWide;
    logic [factPkg::DataWidth-1:0]    mulOut;

    ////////////////////////////////////////////////////////////////////////////
    // multiplier and registers
    ////////////////////////////////////////////////////////////////////////////

    assign countWide = {{(factPkg::DataWidth - factPkg::OperandWidth){1'b0}}, count};
    assign mulOut    = acc * countWide;   // low 32 bits, exact for n <= 12

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            count <= '0;
            acc   <= '0;
        end else if (ctrl.loadOperand) begin
            count <= operand;
            acc   <= {{(factPkg::DataWidth - 1){1'b0}}, 1'b1};   // 0! and 1! stay 1
        end else if (ctrl.mulStep) begin
            acc   <= mulOut;
            count <= count - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // flags
    ////////////////////////////////////////////////////////////////////////////

    // end of count
    assign flags.countAboveOne = (count > factPkg::OperandWidth'(1));

    // operand register upstream holds n steady through the load
    assign flags.outOfRange = (operand > factPkg::OperandWidth'(factPkg::MaxOperand));

    assign product = acc;

endmodule

//--- verilog/factPkg.sv
package factPkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and limits
    ////////////////////////////////////////////////////////////////////////////

    localparam int DataWidth    = 32;   // axi data and result
    localparam int AddrWidth    = 4;    // byte address, four word registers
    localparam int OperandWidth = 4;
    localparam int MaxOperand   = 12;   // 13! overflows 32 bits

    // register offsets, word aligned
    typedef enum logic [AddrWidth-1:0] {
        RegOperand = 4'h0,   // n, read/write
        RegControl = 4'h4,   // wr bit 0 starts, rd bit 0 is busy
        RegStatus  = 4'h8,   // done, error, busy
        RegResult  = 4'hC    // read only
    } regAddr;

    typedef enum logic [2:0] {
        StIdle,
        StLoad,
        StMul,
        StFinish
    } ctrlState;

    ////////////////////////////////////////////////////////////////////////////
    // bus and datapath bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [AddrWidth-1:0]   awaddr;
        logic                   awvalid;
        logic [DataWidth-1:0]   wdata;
        logic [DataWidth/8-1:0] wstrb;
        logic                   wvalid;
        logic                   bready;
        logic [AddrWidth-1:0]   araddr;
        logic                   arvalid;
        logic                   rready;
    } axiLiteReq;

    typedef struct packed {
        logic                 awready;
        logic                 wready;
        logic [1:0]           bresp;
        logic                 bvalid;
        logic                 arready;
        logic [DataWidth-1:0] rdata;
        logic [1:0]           rresp;
        logic                 rvalid;
    } axiLiteRsp;

    typedef struct packed {
        logic loadOperand;   // count <= n, acc <= 1
        logic mulStep;       // acc <= acc * count, count--
    } dpCtrl;

    typedef struct packed {
        logic countAboveOne;
        logic outOfRange;    // n > MaxOperand
    } dpFlags;

endpackage
